/* filelist.f */
+incdir+include
design/gfx_obj_pkg.sv
design/gfx_op_pkg.sv
design/gfx_if.sv
design/object_table.sv
design/object_mem.sv
design/geometry_sequencer.sv
design/vertex_lane.sv
design/object_writeback.sv
design/gfx_matrix_top.sv
verif/gfx_matrix_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= gfx_matrix_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard include/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source, a header or the file list changes
$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# passes only when the bench prints its pass line
run: $(SIM)
	@out="$$(./$(SIM))"; printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(BUILD_DIR)

/* verif/gfx_matrix_testdata.txt */
// op code slot rep chk kind color v0 v1 v2 v3 busy last full map, one command per line
// chk bit0 scans and compares the record, bit1 holds go into the busy window
0 0 00 01 1 3 11 00100020 fff00040 7fff8000 0003fffd 2 00 0 00000001
0 0 01 01 1 2 22 01000200 ff00fe00 00010002 80017ffe 2 01 0 00000003
0 0 02 01 1 1 33 0005fff8 fffb0009 00000000 1234edcc 2 02 0 00000007
3 5 00 01 1 3 11 00150020 fff50040 80048000 0008fffd 4 02 0 00000007
4 c 00 01 1 3 11 0015001c fff5003c 80047ffc 0008fff9 4 02 0 00000007
5 2 01 01 1 2 22 04000800 fc00f800 00040008 0004fff8 4 02 0 00000007
6 3 01 01 1 2 22 00800100 ff80ff00 00000001 0000ffff 4 02 0 00000007
7 0 02 01 3 1 33 fffbfff8 00050009 00000000 edccedcc 4 02 0 00000007
1 0 01 01 2 0 00 00000000 00000000 00000000 00000000 1 02 0 00000005
3 7 01 01 1 2 22 00800100 ff80ff00 00000001 0000ffff 1 02 0 00000005
0 0 01 01 3 0 44 00110022 00330044 00550066 00770088 2 01 0 00000007
0 0 03 1d 1 3 55 01000100 ff000100 ff00ff00 0100ff00 2 03 1 ffffffff
0 0 00 01 0 1 66 00010001 00020002 00030003 00040004 1 1f 1 ffffffff
3 0 00 01 1 3 11 0015001c fff5003c 80047ffc 0008fff9 4 1f 1 ffffffff
2 0 00 01 2 0 00 00000000 00000000 00000000 00000000 1 1f 0 00000000
0 0 00 01 1 2 77 ffffffff 80007fff 0001ffff 4000c000 2 00 0 00000001
5 1 00 01 1 2 77 fffefffe 0000fffe 0002fffe 80008000 4 00 0 00000001
6 f 00 01 1 2 77 ffffffff 0000ffff 0000ffff ffffffff 4 00 0 00000001
7 0 00 01 1 2 77 0001ffff 0000ffff 0000ffff 0001ffff 4 00 0 00000001
4 1 03 01 1 3 55 01000100 ff000100 ff00ff00 0100ff00 1 00 0 00000001
f

/* verif/gfx_matrix_tb.sv */
`include "gfx_settings.svh"

module gfx_matrix_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import gfx_obj_pkg::*;
    import gfx_op_pkg::*;

    localparam int NCOL       = 15;
    localparam int MAX_CMDS   = 32;
    localparam int RST_CYCLES = 8;
    localparam int CMD_CYCLES = 20;

    logic                     clk;
    logic                     arst_n;
    logic                     go;
    gmt_op_t                  gmt_op;
    logic [3:0]               gmt_code;
    logic [`GFX_SLOT_W-1:0]   obj_num;
    obj_kind_t                obj_kind;
    logic [`GFX_COLOR_W-1:0]  obj_color;
    vertex_t [`GFX_VERTS-1:0] vtx_in;
    logic                     scan_rd_en;
    logic [`GFX_SLOT_W-1:0]   scan_addr;
    obj_rec_t                 scan_obj;
    logic                     busy;
    logic                     obj_mem_full;
    logic [`GFX_SLOT_W-1:0]   last_stored_obj;
    logic [`GFX_SLOTS-1:0]    obj_map;

    // one row of NCOL words per command, same column order as the data file
    logic [31:0] td [0:NCOL*MAX_CMDS-1];
    int          n_cmds;
    int          limit_cycles;
    logic        loaded = 1'b0;
    int          checks = 0;
    int          errors = 0;

    gfx_matrix_top dut0 (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic check_obj(input string name, input obj_rec_t got, input obj_rec_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAILED at %0d ns: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_slot(input string name, input logic [`GFX_SLOT_W-1:0] got,
                              input logic [`GFX_SLOT_W-1:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAILED at %0d ns: %s got %0d expected %0d", $time, name, got, want);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAILED at %0d ns: %s got %b expected %b", $time, name, got, want);
        end
    endtask

    task automatic check_map(input string name, input logic [`GFX_SLOTS-1:0] got,
                             input logic [`GFX_SLOTS-1:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAILED at %0d ns: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int want);
        checks++;
        if (got != want) begin
            errors++;
            $display("FAILED at %0d ns: %s got %0d expected %0d", $time, name, got, want);
        end
    endtask

    task automatic report_counts();
        $display("checks %0d, errors %0d", checks, errors);
    endtask

    task automatic scan_slot(input logic [`GFX_SLOT_W-1:0] addr, output obj_rec_t obj);
        @(posedge clk);
        scan_rd_en <= 1'b1;
        scan_addr  <= addr;
        @(posedge clk);
        scan_rd_en <= 1'b0;
        // registered read has landed by the falling edge
        @(negedge clk);
        obj = scan_obj;
    endtask

    // r is the repeat index, slot and last slot step with it
    task automatic run_command(input int b, input int r);
        int                     cycles;
        int                     rep;
        logic                   hold;
        logic [`GFX_SLOT_W-1:0] slot;
        logic [`GFX_SLOT_W-1:0] last;
        obj_rec_t               want;
        obj_rec_t               got;

        rep        = int'(td[b+3]);
        hold       = td[b+4][1];
        slot       = td[b+2][`GFX_SLOT_W-1:0] + r[`GFX_SLOT_W-1:0];
        last       = td[b+12][`GFX_SLOT_W-1:0] + r[`GFX_SLOT_W-1:0];
        want.kind  = obj_kind_t'(td[b+5][1:0]);
        want.color = td[b+6][`GFX_COLOR_W-1:0];
        for (int i = 0; i < `GFX_VERTS; i++) begin
            want.vtx[i] = td[b+7+i];
        end

        @(posedge clk);
        go        <= 1'b1;
        gmt_op    <= gmt_op_t'(td[b][3:0]);
        gmt_code  <= td[b+1][3:0];
        obj_num   <= slot;
        obj_kind  <= want.kind;
        obj_color <= want.color;
        vtx_in    <= want.vtx;
        @(posedge clk);
        // a held go is sampled while the engine is busy
        go     <= hold;
        cycles = 0;
        @(negedge clk);
        while (busy) begin
            cycles++;
            @(posedge clk);
            go <= 1'b0;
            @(negedge clk);
        end

        check_cycles("busy cycles", cycles, int'(td[b+11]));
        check_slot("last_stored_obj", last_stored_obj, last);
        if (r == rep - 1) begin
            check_flag("obj_mem_full", obj_mem_full, td[b+13][0]);
            check_map("obj_map", obj_map, td[b+14][`GFX_SLOTS-1:0]);
        end
        if (td[b+4][0]) begin
            scan_slot(slot, got);
            check_obj("scan_obj", got, want);
        end
    endtask

    initial begin : stimulus
        int runs;

        arst_n     <= 1'b0;
        go         <= 1'b0;
        gmt_op     <= OP_CREATE;
        gmt_code   <= '0;
        obj_num    <= '0;
        obj_kind   <= OBJ_POINT;
        obj_color  <= '0;
        vtx_in     <= '0;
        scan_rd_en <= 1'b0;
        scan_addr  <= '0;

        $readmemh("verif/gfx_matrix_testdata.txt", td);
        n_cmds = 0;
        runs   = 0;
        while (n_cmds < MAX_CMDS && !$isunknown(td[n_cmds*NCOL])
               && td[n_cmds*NCOL] !== 32'hf) begin
            runs += int'(td[n_cmds*NCOL+3]);
            n_cmds++;
        end
        limit_cycles = RST_CYCLES + CMD_CYCLES * (runs + 1);
        loaded       = 1'b1;

        repeat (RST_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("obj_mem_full", obj_mem_full, 1'b0);
        check_slot("last_stored_obj", last_stored_obj, '0);
        check_map("obj_map", obj_map, '0);

        if (n_cmds == 0) begin
            errors++;
            $display("no commands were found, the data file is missing or unreadable");
        end
        for (int c = 0; c < n_cmds; c++) begin
            for (int r = 0; r < int'(td[c*NCOL+3]); r++) begin
                run_command(c * NCOL, r);
            end
        end

        report_counts();
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // limit grows with the number of command runs in the data file
    initial begin : watchdog
        wait (loaded === 1'b1);
        repeat (limit_cycles) @(posedge clk);
        $display("run timed out after %0d cycles before all commands completed", limit_cycles);
        report_counts();
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* design/gfx_matrix_top.sv */
`include "gfx_settings.svh"

module gfx_matrix_top (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  go,
    input  gfx_op_pkg::gmt_op_t                   gmt_op,
    input  logic [3:0]                            gmt_code,
    input  logic [`GFX_SLOT_W-1:0]                obj_num,
    input  gfx_obj_pkg::obj_kind_t                obj_kind,
    input  logic [`GFX_COLOR_W-1:0]               obj_color,
    input  gfx_obj_pkg::vertex_t [`GFX_VERTS-1:0] vtx_in,
    input  logic                                  scan_rd_en,
    input  logic [`GFX_SLOT_W-1:0]                scan_addr,
    output gfx_obj_pkg::obj_rec_t                 scan_obj,
    output logic                                  busy,
    output logic                                  obj_mem_full,
    output logic [`GFX_SLOT_W-1:0]                last_stored_obj,
    output logic [`GFX_SLOTS-1:0]                 obj_map
);
    import gfx_obj_pkg::*;

    logic                     alloc;
    logic                     free;
    logic                     free_all;
    logic [`GFX_SLOT_W-1:0]   slot;
    logic                     in_use;
    logic [`GFX_SLOT_W-1:0]   free_slot;
    logic                     wb_start;
    logic [`GFX_SLOT_W-1:0]   wb_slot;
    obj_kind_t                wb_kind;
    logic [`GFX_COLOR_W-1:0]  wb_color;
    logic [`GFX_VERTS-1:0]    lane_vld;
    vertex_t [`GFX_VERTS-1:0] lane_result;

    obj_mem_if   mem_bus ();
    lane_feed_if feed [`GFX_VERTS-1:0] ();

    object_table u_table (
        .clk(clk), .arst_n(arst_n), .alloc(alloc), .free(free), .free_all(free_all),
        .slot(slot), .in_use(in_use), .free_slot(free_slot), .full(obj_mem_full),
        .last_slot(last_stored_obj), .obj_map(obj_map)
    );

    object_mem u_mem (
        .clk(clk), .mem(mem_bus), .scan_rd_en(scan_rd_en), .scan_addr(scan_addr),
        .scan_obj(scan_obj)
    );

    geometry_sequencer u_seq (
        .clk(clk), .arst_n(arst_n), .go(go), .gmt_op(gmt_op), .gmt_code(gmt_code),
        .obj_num(obj_num), .obj_kind(obj_kind), .obj_color(obj_color), .vtx_in(vtx_in),
        .busy(busy), .alloc(alloc), .free(free), .free_all(free_all), .slot(slot),
        .in_use(in_use), .free_slot(free_slot), .full(obj_mem_full), .mem(mem_bus),
        .feed(feed), .wb_start(wb_start), .wb_slot(wb_slot), .wb_kind(wb_kind),
        .wb_color(wb_color)
    );

    // one lane per vertex
    for (genvar i = 0; i < `GFX_VERTS; i++) begin : g_lane
        vertex_lane u_lane (
            .clk(clk), .arst_n(arst_n), .feed(feed[i]),
            .result_vld(lane_vld[i]), .result(lane_result[i])
        );
    end

    object_writeback u_wb (
        .clk(clk), .arst_n(arst_n), .result_vld(lane_vld), .result(lane_result),
        .wb_start(wb_start), .wb_slot(wb_slot), .wb_kind(wb_kind), .wb_color(wb_color),
        .mem(mem_bus)
    );

endmodule

/* design/object_writeback.sv */
`include "gfx_settings.svh"

module object_writeback (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic [`GFX_VERTS-1:0]                 result_vld,
    input  gfx_obj_pkg::vertex_t [`GFX_VERTS-1:0] result,
    input  logic                                  wb_start,
    input  logic [`GFX_SLOT_W-1:0]                wb_slot,
    input  gfx_obj_pkg::obj_kind_t                wb_kind,
    input  logic [`GFX_COLOR_W-1:0]               wb_color,
    obj_mem_if.writeback                          mem
);
    import gfx_obj_pkg::*;

    logic                    pending;
    logic                    all_vld;
    logic [`GFX_SLOT_W-1:0]  slot_q;
    obj_kind_t               kind_q;
    logic [`GFX_COLOR_W-1:0] color_q;

    assign all_vld = &result_vld;

    // armed by the sequencer, cleared by the write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 1'b0;
        end else if (wb_start) begin
            pending <= 1'b1;
        end else if (all_vld) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_start) begin
            slot_q  <= wb_slot;
            kind_q  <= wb_kind;
            color_q <= wb_color;
        end
    end

    assign mem.wb_wr_en = pending && all_vld;
    assign mem.wb_addr  = slot_q;
    assign mem.wb_wdata = '{kind: kind_q, color: color_q, vtx: result};

endmodule

/* design/vertex_lane.sv */
`include "gfx_settings.svh"

module vertex_lane (
    input  logic                 clk,
    input  logic                 arst_n,
    lane_feed_if.lane            feed,
    output logic                 result_vld,
    output gfx_obj_pkg::vertex_t result
);
    import gfx_obj_pkg::*;
    import gfx_op_pkg::*;

    logic signed [`GFX_COORD_W-1:0] delta;
    vertex_t                        vin;
    vertex_t                        vout;

    assign vin = feed.item.vtx;
    // translate step, code taken as signed
    assign delta = {{(`GFX_COORD_W-4){feed.item.code[3]}}, feed.item.code};

    always_comb begin
        vout = vin;
        case (feed.item.op)
            OP_TRANS_X: vout.x = vin.x + delta;
            OP_TRANS_Y: vout.y = vin.y + delta;
            OP_SCALE_UP: begin
                vout.x = vin.x <<< feed.item.code;
                vout.y = vin.y <<< feed.item.code;
            end
            OP_SCALE_DN: begin
                vout.x = vin.x >>> feed.item.code;
                vout.y = vin.y >>> feed.item.code;
            end
            OP_MIRROR_X: vout.x = -vin.x;
            default: vout = vin;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_vld <= 1'b0;
        end else begin
            result_vld <= feed.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (feed.valid) begin
            result <= vout;
        end
    end

endmodule

/* design/geometry_sequencer.sv */
`include "gfx_settings.svh"

module geometry_sequencer (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  go,
    input  gfx_op_pkg::gmt_op_t                   gmt_op,
    input  logic [3:0]                            gmt_code,
    input  logic [`GFX_SLOT_W-1:0]                obj_num,
    input  gfx_obj_pkg::obj_kind_t                obj_kind,
    input  logic [`GFX_COLOR_W-1:0]               obj_color,
    input  gfx_obj_pkg::vertex_t [`GFX_VERTS-1:0] vtx_in,
    output logic                                  busy,
    output logic                                  alloc,
    output logic                                  free,
    output logic                                  free_all,
    output logic [`GFX_SLOT_W-1:0]                slot,
    input  logic                                  in_use,
    input  logic [`GFX_SLOT_W-1:0]                free_slot,
    input  logic                                  full,
    obj_mem_if.engine                             mem,
    lane_feed_if.feeder                           feed [`GFX_VERTS-1:0],
    output logic                                  wb_start,
    output logic [`GFX_SLOT_W-1:0]                wb_slot,
    output gfx_obj_pkg::obj_kind_t                wb_kind,
    output logic [`GFX_COLOR_W-1:0]               wb_color
);
    import gfx_obj_pkg::*;
    import gfx_op_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_FEED,
        ST_WAIT,
        ST_WRITE
    } state_t;

    state_t                   state;
    state_t                   state_nxt;
    logic                     crt_q;
    gmt_op_t                  op_q;
    logic [3:0]               code_q;
    logic [`GFX_SLOT_W-1:0]   slot_q;
    obj_kind_t                kind_q;
    logic [`GFX_COLOR_W-1:0]  color_q;
    vertex_t [`GFX_VERTS-1:0] vtx_q;

    // create: write, wait. transform: read, feed, wait, write
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (go) begin
                    case (gmt_op)
                        OP_CREATE, OP_DELETE, OP_DELETE_ALL: state_nxt = ST_WRITE;
                        OP_TRANS_X, OP_TRANS_Y, OP_SCALE_UP, OP_SCALE_DN, OP_MIRROR_X:
                            state_nxt = in_use ? ST_READ : ST_WRITE;
                        default: state_nxt = ST_IDLE;
                    endcase
                end
            end
            ST_READ:  state_nxt = ST_FEED;
            ST_FEED:  state_nxt = ST_WAIT;
            ST_WAIT:  state_nxt = crt_q ? ST_IDLE : ST_WRITE;
            ST_WRITE: state_nxt = crt_q ? ST_WAIT : ST_IDLE;
            default:  state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
            crt_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == ST_IDLE && go) begin
                // a create on a full store runs as a one-cycle no-op
                crt_q <= (gmt_op == OP_CREATE) && !full;
            end
        end
    end

    // command operands
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && go) begin
            op_q    <= gmt_op;
            code_q  <= gmt_code;
            slot_q  <= (gmt_op == OP_CREATE) ? free_slot : obj_num;
            kind_q  <= obj_kind;
            color_q <= obj_color;
            vtx_q   <= vtx_in;
        end
    end

    assign busy     = (state != ST_IDLE);
    assign alloc    = (state == ST_WRITE) && crt_q;
    assign free     = (state == ST_WRITE) && (op_q == OP_DELETE);
    assign free_all = (state == ST_WRITE) && (op_q == OP_DELETE_ALL);
    // idle shows the host slot so in_use is ready at go
    assign slot     = (state == ST_IDLE) ? obj_num : slot_q;

    assign mem.rd_en     = (state == ST_READ);
    assign mem.eng_wr_en = alloc;
    assign mem.eng_addr  = slot_q;
    assign mem.eng_wdata = '{kind: kind_q, color: color_q, vtx: vtx_q};

    // rdata is valid while in feed
    assign wb_start = (state == ST_FEED);
    assign wb_slot  = slot_q;
    assign wb_kind  = mem.rdata.kind;
    assign wb_color = mem.rdata.color;

    for (genvar i = 0; i < `GFX_VERTS; i++) begin : g_feed
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                feed[i].valid <= 1'b0;
            end else begin
                feed[i].valid <= (state == ST_FEED);
            end
        end

        always_ff @(posedge clk) begin
            if (state == ST_FEED) begin
                feed[i].item <= '{op: op_q, code: code_q, vtx: mem.rdata.vtx[i]};
            end
        end
    end

endmodule

/* design/object_mem.sv */
`include "gfx_settings.svh"

module object_mem (
    input  logic                   clk,
    obj_mem_if.memory              mem,
    input  logic                   scan_rd_en,
    input  logic [`GFX_SLOT_W-1:0] scan_addr,
    output gfx_obj_pkg::obj_rec_t  scan_obj
);
    import gfx_obj_pkg::*;

    obj_rec_t ram [`GFX_SLOTS];

    // engine port, read returns old data on a same-slot write
    always_ff @(posedge clk) begin
        if (mem.wr_en) begin
            ram[mem.addr] <= mem.wdata;
        end
        if (mem.rd_en) begin
            mem.rdata <= ram[mem.addr];
        end
    end

    // clipper scan port
    always_ff @(posedge clk) begin
        if (scan_rd_en) begin
            scan_obj <= ram[scan_addr];
        end
    end

endmodule

/* design/object_table.sv */
`include "gfx_settings.svh"

module object_table (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   alloc,
    input  logic                   free,
    input  logic                   free_all,
    input  logic [`GFX_SLOT_W-1:0] slot,
    output logic                   in_use,
    output logic [`GFX_SLOT_W-1:0] free_slot,
    output logic                   full,
    output logic [`GFX_SLOT_W-1:0] last_slot,
    output logic [`GFX_SLOTS-1:0]  obj_map
);

    logic [`GFX_SLOTS-1:0] used;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            used      <= '0;
            last_slot <= '0;
        end else begin
            if (free_all) begin
                used <= '0;
            end else if (free) begin
                used[slot] <= 1'b0;
            end else if (alloc) begin
                used[slot] <= 1'b1;
                last_slot  <= slot;
            end
        end
    end

    // lowest clear bit wins
    always_comb begin
        free_slot = '0;
        for (int i = `GFX_SLOTS - 1; i >= 0; i--) begin
            if (!used[i]) begin
                free_slot = i[`GFX_SLOT_W-1:0];
            end
        end
    end

    assign in_use  = used[slot];
    assign full    = &used;
    assign obj_map = used;

endmodule

/* design/gfx_if.sv */
`include "gfx_settings.svh"

interface lane_feed_if;
    import gfx_op_pkg::*;

    logic       valid;
    lane_item_t item;

    modport feeder (output valid, output item);
    modport lane (input valid, input item);
endinterface

interface obj_mem_if;
    import gfx_obj_pkg::*;

    logic                   rd_en;
    logic                   wr_en;
    logic [`GFX_SLOT_W-1:0] addr;
    obj_rec_t               wdata;
    obj_rec_t               rdata;

    // write requests from each side
    logic                   eng_wr_en;
    logic [`GFX_SLOT_W-1:0] eng_addr;
    obj_rec_t               eng_wdata;
    logic                   wb_wr_en;
    logic [`GFX_SLOT_W-1:0] wb_addr;
    obj_rec_t               wb_wdata;

    // sequencer state keeps both writers apart, writeback wins the mux
    assign wr_en = eng_wr_en | wb_wr_en;
    assign addr  = wb_wr_en ? wb_addr : eng_addr;
    assign wdata = wb_wr_en ? wb_wdata : eng_wdata;

    modport memory (input rd_en, input wr_en, input addr, input wdata, output rdata);
    modport engine (output rd_en, output eng_wr_en, output eng_addr, output eng_wdata,
                    input rdata);
    modport writeback (output wb_wr_en, output wb_addr, output wb_wdata);
endinterface

/* design/gfx_op_pkg.sv */
package gfx_op_pkg;

    // host command codes
    typedef enum logic [3:0] {
        OP_CREATE,
        OP_DELETE,
        OP_DELETE_ALL,
        OP_TRANS_X,
        OP_TRANS_Y,
        OP_SCALE_UP,
        OP_SCALE_DN,
        OP_MIRROR_X
    } gmt_op_t;

    // work item handed to one vertex lane
    typedef struct packed {
        gmt_op_t              op;
        logic [3:0]           code;
        gfx_obj_pkg::vertex_t vtx;
    } lane_item_t;

endpackage

/* design/gfx_obj_pkg.sv */
`include "gfx_settings.svh"

package gfx_obj_pkg;

    // polygon class of a stored object
    typedef enum logic [1:0] {
        OBJ_POINT,
        OBJ_LINE,
        OBJ_TRI,
        OBJ_QUAD
    } obj_kind_t;

    // one corner, x in the upper half
    typedef struct packed {
        logic signed [`GFX_COORD_W-1:0] x;
        logic signed [`GFX_COORD_W-1:0] y;
    } vertex_t;

    // full record as held in the object memory, 138 bits
    typedef struct packed {
        obj_kind_t                  kind;
        logic [`GFX_COLOR_W-1:0]    color;
        vertex_t [`GFX_VERTS-1:0]   vtx;
    } obj_rec_t;

endpackage

/* include/gfx_settings.svh */
`ifndef GFX_SETTINGS_SVH
`define GFX_SETTINGS_SVH

// object store size
`define GFX_SLOTS 32

// vertices per object
`define GFX_VERTS 4

// signed coordinate width
`define GFX_COORD_W 16

`define GFX_COLOR_W 8

// slot index width follows the slot count
`define GFX_SLOT_W $clog2(`GFX_SLOTS)

`endif
